// ==== flist.f ====
common/wb_pkg.sv
hw/wb_latch.sv
writeback/wb_route.sv
writeback/wb_queue.sv
hw/arch_regs.sv
hw/wb_top.sv
tests/wb_clock.sv
tests/wb_props.sv
tests/wb_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= wb_tb
FLIST     ?= flist.f
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100000

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP) -f $(FLIST)
	-./$(BUILD_DIR)/$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failures found" $(LOG) || ! grep -q "All tests passed!" $(LOG); then \
		echo "FAIL: see $(LOG)"; \
		exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/wb_tb.sv ====
module wb_tb;

    localparam int N_INSTR    = 400;
    localparam int PERIOD     = 40;
    localparam int CYC_BOUND  = 24;  // generous cycles per instruction with stalls
    localparam int LOW_CYCLES = 60;  // long dcache_ready low stretch

    logic              clk;
    logic              rst;
    logic              ex_valid;
    wb_pkg::ex_wb_t    ex_data;
    logic              interrupt;
    logic              dcache_ready;
    logic              stall;
    logic              mem_valid;
    wb_pkg::mem_wr_t   mem_data;
    wb_pkg::redirect_t redirect;
    logic              exc_valid;
    logic [3:0]        exc_type;
    logic              halt;
    logic              halt_flop;
    logic [2:0]        gpr_raddr_a;
    logic [2:0]        gpr_raddr_b;
    logic [2:0]        seg_raddr;
    logic [31:0]       gpr_rdata_a;
    logic [31:0]       gpr_rdata_b;
    logic [15:0]       seg_rdata;
    logic [31:0]       lfsr = 32'h9755;
    logic [2:0]        sweep;
    int                low_left;
    int                errors;

    wb_clock #(.PERIOD(PERIOD), .RST_CYCLES(3)) i_clk (.clk(clk), .rst(rst));

    wb_top #(.QUEUE_DEPTH(4)) i_dut (
        .clk(clk), .rst(rst), .ex_valid(ex_valid), .ex_data(ex_data),
        .interrupt(interrupt), .dcache_ready(dcache_ready), .stall(stall),
        .mem_valid(mem_valid), .mem_data(mem_data), .redirect(redirect),
        .exc_valid(exc_valid), .exc_type(exc_type), .halt(halt), .halt_flop(halt_flop),
        .gpr_raddr_a(gpr_raddr_a), .gpr_raddr_b(gpr_raddr_b), .seg_raddr(seg_raddr),
        .gpr_rdata_a(gpr_rdata_a), .gpr_rdata_b(gpr_rdata_b), .seg_rdata(seg_rdata)
    );

    bind wb_top wb_props #(.DEPTH(QUEUE_DEPTH)) i_props (
        .clk(clk), .rst(rst), .ex_valid(ex_valid), .ex_data(ex_data),
        .interrupt(interrupt), .dcache_ready(dcache_ready), .stall(stall),
        .mem_valid(mem_valid), .mem_data(mem_data), .redirect(redirect),
        .exc_valid(exc_valid), .exc_type(exc_type), .halt(halt), .halt_flop(halt_flop),
        .gpr_raddr_a(gpr_raddr_a), .gpr_raddr_b(gpr_raddr_b), .seg_raddr(seg_raddr),
        .gpr_rdata_a(gpr_rdata_a), .gpr_rdata_b(gpr_rdata_b), .seg_rdata(seg_rdata)
    );

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic wb_pkg::ex_wb_t random_instr();
        wb_pkg::ex_wb_t d;
        for (int i = 0; i < wb_pkg::NUM_SLOTS; i++) begin
            d.slots[i].value = {rand_bits(32), rand_bits(32)};
            d.slots[i].dest  = rand_bits(32);
            d.slots[i].kind  = wb_pkg::slot_kind_e'(2'(rand_bits(2)));
            d.slots[i].wb    = (rand_bits(2) != 0);  // mostly enabled
        end
        d.size       = 2'(rand_bits(2));
        d.eip        = rand_bits(32);
        d.eip_next   = rand_bits(32);
        d.br_valid   = 1'(rand_bits(1));
        d.br_taken   = 1'(rand_bits(1));
        d.br_correct = 1'(rand_bits(1));
        d.br_target  = rand_bits(32);
        d.ld_eip_cs  = (rand_bits(2) == 0);
        d.cs         = 16'(rand_bits(16));
        d.exc        = (rand_bits(3) == 0);
        d.exc_type   = 3'(rand_bits(3));
        d.halt_op    = (rand_bits(7) == 0);  // rare
        return d;
    endfunction

    // one falling edge: read sweep, interrupt and cache readiness
    task automatic next_cycle();
        @(negedge clk);
        gpr_raddr_a = sweep;
        gpr_raddr_b = sweep + 3'd3;
        seg_raddr   = sweep + 3'd5;
        sweep++;
        interrupt = (rand_bits(4) == 0);
        if (low_left > 0) begin
            dcache_ready = 1'b0;
            low_left--;
        end else begin
            dcache_ready = (rand_bits(2) != 0);
        end
    endtask

    // held until an edge with stall low takes it
    task automatic send(input logic v, input wb_pkg::ex_wb_t d);
        next_cycle();
        ex_valid = v;
        ex_data  = d;
        while (stall) begin
            next_cycle();
        end
    endtask

    initial begin
        ex_valid     = 1'b0;
        ex_data      = '0;
        interrupt    = 1'b0;
        dcache_ready = 1'b0;
        gpr_raddr_a  = '0;
        gpr_raddr_b  = '0;
        seg_raddr    = '0;
        sweep        = '0;
        low_left     = 0;
        wait (!rst);
        for (int n = 0; n < N_INSTR; n++) begin
            if (n == N_INSTR / 3) begin
                low_left = LOW_CYCLES;
            end
            if (rand_bits(2) == 0) begin
                send(1'b0, ex_data);  // bubble
            end
            send(1'b1, random_instr());
        end
        send(1'b0, ex_data);
        repeat (2) next_cycle();
        while (mem_valid) begin
            next_cycle();
        end
        repeat (4) next_cycle();
        errors = i_dut.i_props.fail_cnt;
        $display("summary: %0d assertion failures over %0d instructions", errors, N_INSTR);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(PERIOD * (N_INSTR * CYC_BOUND + LOW_CYCLES + 50));
        $display("watchdog: the run did not finish in time and was stopped");
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== tests/wb_props.sv ====
module wb_props #(
    parameter int DEPTH = 4
) (
    input logic              clk,
    input logic              rst,
    input logic              ex_valid,
    input wb_pkg::ex_wb_t    ex_data,
    input logic              interrupt,
    input logic              dcache_ready,
    input logic              stall,
    input logic              mem_valid,
    input wb_pkg::mem_wr_t   mem_data,
    input wb_pkg::redirect_t redirect,
    input logic              exc_valid,
    input logic [3:0]        exc_type,
    input logic              halt,
    input logic              halt_flop,
    input logic [2:0]        gpr_raddr_a,
    input logic [2:0]        gpr_raddr_b,
    input logic [2:0]        seg_raddr,
    input logic [31:0]       gpr_rdata_a,
    input logic [31:0]       gpr_rdata_b,
    input logic [15:0]       seg_rdata
);

    logic [31:0]     sh_gpr [8];
    logic [15:0]     sh_seg [8];
    wb_pkg::mem_wr_t sh_q [DEPTH];   // expected store stream
    int              sh_rd;
    int              sh_wr;
    int              sh_cnt;
    logic            sh_valid;       // shadow of the input latch
    wb_pkg::ex_wb_t  sh_data;
    logic            sh_has_mem;
    wb_pkg::mem_wr_t sh_store;
    logic            sh_stall;
    logic            sh_retire;
    logic            sh_push;
    logic            sh_pop;
    logic            sh_halt;
    logic [31:0]     exp_eip;
    int              fail_cnt = 0;

    task automatic count_failure(input string msg);
        fail_cnt++;
        $error("%s", msg);
    endtask

    // first enabled memory slot is the store with the instruction's size
    always_comb begin
        sh_has_mem = 1'b0;
        sh_store   = '0;
        for (int i = 0; i < wb_pkg::NUM_SLOTS; i++) begin
            if (!sh_has_mem && sh_data.slots[i].wb && sh_data.slots[i].kind == wb_pkg::KIND_MEM) begin
                sh_has_mem    = 1'b1;
                sh_store.addr = sh_data.slots[i].dest;
                sh_store.data = sh_data.slots[i].value;
            end
        end
        sh_store.size = sh_data.size;
    end

    assign sh_stall  = sh_valid && sh_has_mem && (sh_cnt == DEPTH);
    assign sh_retire = sh_valid && !sh_stall;
    assign sh_push   = sh_retire && sh_has_mem;
    assign sh_pop    = (sh_cnt != 0) && dcache_ready;

    // far transfers take EIP from slot 1
    assign exp_eip = !sh_data.br_taken ? sh_data.eip_next :
                     sh_data.ld_eip_cs ? sh_data.slots[1].value[31:0] : sh_data.br_target;

    always_ff @(posedge clk) begin
        if (!sh_stall && ex_valid) begin
            sh_data <= ex_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sh_valid <= 1'b0;
            sh_halt  <= 1'b0;
            sh_rd    <= 0;
            sh_wr    <= 0;
            sh_cnt   <= 0;
            for (int r = 0; r < 8; r++) begin
                sh_gpr[r] <= '0;
                sh_seg[r] <= '0;
            end
        end else begin
            if (!sh_stall) begin
                sh_valid <= ex_valid;
            end
            if (sh_retire) begin
                // ascending order so the later slot wins
                for (int i = 0; i < wb_pkg::NUM_SLOTS; i++) begin
                    if (sh_data.slots[i].wb && sh_data.slots[i].kind == wb_pkg::KIND_REG) begin
                        sh_gpr[sh_data.slots[i].dest[2:0]] <= sh_data.slots[i].value[31:0];
                    end
                    if (sh_data.slots[i].wb && sh_data.slots[i].kind == wb_pkg::KIND_SEG) begin
                        sh_seg[sh_data.slots[i].dest[2:0]] <= sh_data.slots[i].value[15:0];
                    end
                end
                if (sh_data.halt_op) begin
                    sh_halt <= 1'b1;
                end
            end
            if (sh_push) begin
                sh_q[sh_wr] <= sh_store;
                sh_wr       <= (sh_wr == DEPTH - 1) ? 0 : sh_wr + 1;
            end
            if (sh_pop) begin
                sh_rd <= (sh_rd == DEPTH - 1) ? 0 : sh_rd + 1;
            end
            sh_cnt <= sh_cnt + int'(sh_push) - int'(sh_pop);
        end
    end

    a_gpr_a: assert property (@(posedge clk) disable iff (rst) gpr_rdata_a == sh_gpr[gpr_raddr_a])
        else count_failure($sformatf("CHECK FAILED gpr_rdata_a got %h exp %h",
                                     gpr_rdata_a, sh_gpr[gpr_raddr_a]));
    a_gpr_b: assert property (@(posedge clk) disable iff (rst) gpr_rdata_b == sh_gpr[gpr_raddr_b])
        else count_failure($sformatf("CHECK FAILED gpr_rdata_b got %h exp %h",
                                     gpr_rdata_b, sh_gpr[gpr_raddr_b]));
    a_seg: assert property (@(posedge clk) disable iff (rst) seg_rdata == sh_seg[seg_raddr])
        else count_failure($sformatf("CHECK FAILED seg_rdata got %h exp %h",
                                     seg_rdata, sh_seg[seg_raddr]));
    a_mem_valid: assert property (@(posedge clk) disable iff (rst) mem_valid == (sh_cnt != 0))
        else count_failure($sformatf("CHECK FAILED mem_valid got %h exp %h",
                                     mem_valid, sh_cnt != 0));
    a_store: assert property (@(posedge clk) disable iff (rst)
                              (mem_valid && dcache_ready) |-> mem_data == sh_q[sh_rd])
        else count_failure($sformatf("CHECK FAILED mem_data got %h exp %h",
                                     mem_data, sh_q[sh_rd]));
    a_stall: assert property (@(posedge clk) disable iff (rst) stall == sh_stall)
        else count_failure($sformatf("CHECK FAILED stall got %h exp %h", stall, sh_stall));
    a_resteer: assert property (@(posedge clk) disable iff (rst)
                                redirect.resteer == (sh_retire && sh_data.br_valid &&
                                                     !sh_data.br_correct))
        else count_failure($sformatf("CHECK FAILED resteer got %h exp %h", redirect.resteer,
                                     sh_retire && sh_data.br_valid && !sh_data.br_correct));
    a_new_eip: assert property (@(posedge clk) disable iff (rst)
                                sh_retire |-> redirect.new_eip == exp_eip)
        else count_failure($sformatf("CHECK FAILED new_eip got %h exp %h",
                                     redirect.new_eip, exp_eip));
    // even line has bit 4 clear and odd line has it set
    a_fetch_lines: assert property (@(posedge clk) disable iff (rst) sh_retire |->
                                    redirect.fip_o == {exp_eip[31:5], 5'h10} &&
                                    redirect.fip_e == {exp_eip[31:5], 5'h00} +
                                                      (exp_eip[4] ? 32'd32 : 32'd0))
        else count_failure($sformatf("CHECK FAILED fip_e/fip_o got %h/%h for eip %h",
                                     redirect.fip_e, redirect.fip_o, exp_eip));
    a_exc: assert property (@(posedge clk) disable iff (rst)
                            exc_valid == (sh_retire && (sh_data.exc || interrupt)) &&
                            (!sh_retire || exc_type == {interrupt, sh_data.exc_type}))
        else count_failure($sformatf("CHECK FAILED exc_valid/exc_type got %h/%h exp %h/%h",
                                     exc_valid, exc_type,
                                     sh_retire && (sh_data.exc || interrupt),
                                     {interrupt, sh_data.exc_type}));
    a_halt: assert property (@(posedge clk) disable iff (rst)
                             halt == (sh_retire && sh_data.halt_op) && halt_flop == sh_halt)
        else count_failure($sformatf("CHECK FAILED halt/halt_flop got %h/%h exp flop %h",
                                     halt, halt_flop, sh_halt));

endmodule

// ==== tests/wb_clock.sv ====
module wb_clock #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;  // released on a falling edge
    end

endmodule

// ==== hw/wb_top.sv ====
module wb_top #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       ex_valid,
    input  wb_pkg::ex_wb_t             ex_data,
    input  logic                       interrupt,
    input  logic                       dcache_ready,
    output logic                       stall,
    output logic                       mem_valid,
    output wb_pkg::mem_wr_t            mem_data,
    output wb_pkg::redirect_t          redirect,
    output logic                       exc_valid,
    output logic [3:0]                 exc_type,
    output logic                       halt,
    output logic                       halt_flop,
    input  logic [wb_pkg::REG_AW-1:0]  gpr_raddr_a,
    input  logic [wb_pkg::REG_AW-1:0]  gpr_raddr_b,
    input  logic [wb_pkg::REG_AW-1:0]  seg_raddr,
    output logic [31:0]                gpr_rdata_a,
    output logic [31:0]                gpr_rdata_b,
    output logic [15:0]                seg_rdata
);

    logic                                             wb_valid;
    wb_pkg::ex_wb_t                                   wb_data;
    logic                                             q_full;
    logic [wb_pkg::NUM_SLOTS-1:0]                     gpr_we;
    logic [wb_pkg::NUM_SLOTS-1:0]                     seg_we;
    logic [wb_pkg::NUM_SLOTS-1:0][wb_pkg::REG_AW-1:0] gpr_waddr;
    logic [wb_pkg::NUM_SLOTS-1:0][wb_pkg::REG_AW-1:0] seg_waddr;
    logic [wb_pkg::NUM_SLOTS-1:0][31:0]               gpr_wdata;
    logic [wb_pkg::NUM_SLOTS-1:0][15:0]               seg_wdata;
    logic                                             enq;
    wb_pkg::mem_wr_t                                  enq_data;

    wb_latch i_latch (
        .clk      (clk),
        .rst      (rst),
        .ex_valid (ex_valid),
        .ex_data  (ex_data),
        .stall    (stall),
        .wb_valid (wb_valid),
        .wb_data  (wb_data)
    );

    wb_route i_route (
        .clk       (clk),
        .rst       (rst),
        .wb_valid  (wb_valid),
        .wb_data   (wb_data),
        .q_full    (q_full),
        .interrupt (interrupt),
        .stall     (stall),
        .gpr_we    (gpr_we),
        .seg_we    (seg_we),
        .gpr_waddr (gpr_waddr),
        .seg_waddr (seg_waddr),
        .gpr_wdata (gpr_wdata),
        .seg_wdata (seg_wdata),
        .enq       (enq),
        .enq_data  (enq_data),
        .redirect  (redirect),
        .exc_valid (exc_valid),
        .exc_type  (exc_type),
        .halt      (halt),
        .halt_flop (halt_flop)
    );

    // writeback address queue toward the data cache
    wb_queue #(
        .entry_t (wb_pkg::mem_wr_t),
        .DEPTH   (QUEUE_DEPTH)
    ) i_queue (
        .clk       (clk),
        .rst       (rst),
        .enq       (enq),
        .enq_data  (enq_data),
        .deq_ready (dcache_ready),
        .valid     (mem_valid),
        .head      (mem_data),
        .full      (q_full)
    );

    arch_regs #(.WIDTH(32)) i_gpr (
        .clk     (clk),
        .rst     (rst),
        .we      (gpr_we),
        .waddr   (gpr_waddr),
        .wdata   (gpr_wdata),
        .raddr_a (gpr_raddr_a),
        .raddr_b (gpr_raddr_b),
        .rdata_a (gpr_rdata_a),
        .rdata_b (gpr_rdata_b)
    );

    // segment file only needs one read port
    arch_regs #(.WIDTH(16)) i_seg (
        .clk     (clk),
        .rst     (rst),
        .we      (seg_we),
        .waddr   (seg_waddr),
        .wdata   (seg_wdata),
        .raddr_a (seg_raddr),
        .raddr_b (seg_raddr),
        .rdata_a (seg_rdata),
        .rdata_b ()
    );

endmodule

// ==== hw/arch_regs.sv ====
module arch_regs #(
    parameter int WIDTH = 32
) (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic [wb_pkg::NUM_SLOTS-1:0]                     we,
    input  logic [wb_pkg::NUM_SLOTS-1:0][wb_pkg::REG_AW-1:0] waddr,
    input  logic [wb_pkg::NUM_SLOTS-1:0][WIDTH-1:0]          wdata,
    input  logic [wb_pkg::REG_AW-1:0]                        raddr_a,
    input  logic [wb_pkg::REG_AW-1:0]                        raddr_b,
    output logic [WIDTH-1:0]                                 rdata_a,
    output logic [WIDTH-1:0]                                 rdata_b
);

    localparam int NREGS = 1 << wb_pkg::REG_AW;

    logic [WIDTH-1:0] regs [NREGS];

    // ports applied in ascending order, so on a collision the
    // higher-numbered slot lands last, as x86 multi-result ops expect
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NREGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int p = 0; p < wb_pkg::NUM_SLOTS; p++) begin
                if (we[p]) begin
                    regs[waddr[p]] <= wdata[p];
                end
            end
        end
    end

    // asynchronous read, shows a write from the following cycle
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

// ==== writeback/wb_queue.sv ====
module wb_queue #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 4
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   enq,
    input  entry_t enq_data,
    input  logic   deq_ready,
    output logic   valid,
    output entry_t head,
    output logic   full
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    entry_t        mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_enq;
    logic          do_deq;

    // wrap that also works for depths that are not a power of two
    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        if (ptr == PW'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign valid  = (count != '0);
    assign full   = (count == CW'(DEPTH));
    assign head   = mem[rd_ptr];
    assign do_enq = enq && !full;
    assign do_deq = valid && deq_ready;  // cache takes the head

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_enq) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_deq) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_enq, do_deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle or pass-through
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            mem[wr_ptr] <= enq_data;
        end
    end

endmodule

// ==== writeback/wb_route.sv ====
module wb_route (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic                                               wb_valid,
    input  wb_pkg::ex_wb_t                                     wb_data,
    input  logic                                               q_full,
    input  logic                                               interrupt,
    output logic                                               stall,
    output logic [wb_pkg::NUM_SLOTS-1:0]                       gpr_we,
    output logic [wb_pkg::NUM_SLOTS-1:0]                       seg_we,
    output logic [wb_pkg::NUM_SLOTS-1:0][wb_pkg::REG_AW-1:0]   gpr_waddr,
    output logic [wb_pkg::NUM_SLOTS-1:0][wb_pkg::REG_AW-1:0]   seg_waddr,
    output logic [wb_pkg::NUM_SLOTS-1:0][31:0]                 gpr_wdata,
    output logic [wb_pkg::NUM_SLOTS-1:0][15:0]                 seg_wdata,
    output logic                                               enq,
    output wb_pkg::mem_wr_t                                    enq_data,
    output wb_pkg::redirect_t                                  redirect,
    output logic                                               exc_valid,
    output logic [3:0]                                         exc_type,
    output logic                                               halt,
    output logic                                               halt_flop
);

    logic                         retire;
    logic [wb_pkg::NUM_SLOTS-1:0] mem_hit;   // wb-enabled memory slots
    logic                         has_mem;
    logic [31:0]                  new_eip;
    logic [31:0]                  line_cur;
    logic [31:0]                  line_nxt;

    always_comb begin
        for (int i = 0; i < wb_pkg::NUM_SLOTS; i++) begin
            mem_hit[i] = wb_data.slots[i].wb && (wb_data.slots[i].kind == wb_pkg::KIND_MEM);
        end
    end

    assign has_mem = wb_valid && (|mem_hit);
    assign stall   = has_mem && q_full;  // store has nowhere to go
    assign retire  = wb_valid && !stall;

    // one register and one segment write port per slot
    always_comb begin
        for (int i = 0; i < wb_pkg::NUM_SLOTS; i++) begin
            gpr_we[i]    = retire && wb_data.slots[i].wb &&
                           (wb_data.slots[i].kind == wb_pkg::KIND_REG);
            seg_we[i]    = retire && wb_data.slots[i].wb &&
                           (wb_data.slots[i].kind == wb_pkg::KIND_SEG);
            gpr_waddr[i] = wb_data.slots[i].dest[wb_pkg::REG_AW-1:0];
            seg_waddr[i] = wb_data.slots[i].dest[wb_pkg::REG_AW-1:0];
            gpr_wdata[i] = wb_data.slots[i].value[31:0];
            seg_wdata[i] = wb_data.slots[i].value[15:0];
        end
    end

    // lowest memory slot wins and the rest are dropped
    always_comb begin
        enq_data = '0;
        for (int i = wb_pkg::NUM_SLOTS - 1; i >= 0; i--) begin
            if (mem_hit[i]) begin
                enq_data.addr = wb_data.slots[i].dest;
                enq_data.data = wb_data.slots[i].value;
            end
        end
        enq_data.size = wb_data.size;
    end

    assign enq = retire && has_mem;

    // next fetch address
    always_comb begin
        if (!wb_data.br_taken) begin
            new_eip = wb_data.eip_next;
        end else if (wb_data.ld_eip_cs) begin
            new_eip = wb_data.slots[1].value[31:0];  // far jump or call takes EIP from slot 1
        end else begin
            new_eip = wb_data.br_target;
        end
    end

    assign line_cur = {new_eip[31:4], 4'h0};
    assign line_nxt = line_cur + 32'd16;

    always_comb begin
        redirect.resteer = retire && wb_data.br_valid && !wb_data.br_correct;
        redirect.new_eip = new_eip;
        // bit 4 says whether the current line is the odd bank
        redirect.fip_e   = new_eip[4] ? line_nxt : line_cur;
        redirect.fip_o   = new_eip[4] ? line_cur : line_nxt;
    end

    // external interrupt merged in and flagged in the top type bit
    assign exc_valid = retire && (wb_data.exc || interrupt);
    assign exc_type  = {interrupt, wb_data.exc_type};

    assign halt = retire && wb_data.halt_op;

    always_ff @(posedge clk) begin
        if (rst) begin
            halt_flop <= 1'b0;
        end else if (halt) begin
            halt_flop <= 1'b1;  // sticky until reset
        end
    end

endmodule

// ==== hw/wb_latch.sv ====
module wb_latch (
    input  logic           clk,
    input  logic           rst,
    input  logic           ex_valid,
    input  wb_pkg::ex_wb_t ex_data,
    input  logic           stall,
    output logic           wb_valid,
    output wb_pkg::ex_wb_t wb_data
);

    // pipeline register between execute and writeback
    //
    // execute holds its strobe and payload while stall is high, so the
    // latch simply freezes. when not stalled the latch takes whatever
    // execute presents; a retiring instruction with nothing behind it
    // leaves valid low so it cannot retire a second time

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else if (!stall) begin
            wb_valid <= ex_valid;  // drops to 0 on a bubble
        end
    end

    // payload only moves with a real instruction
    always_ff @(posedge clk) begin
        if (!stall && ex_valid) begin
            wb_data <= ex_data;
        end
    end

endmodule

// ==== common/wb_pkg.sv ====
package wb_pkg;

    localparam int NUM_SLOTS = 4;  // result slots per instruction
    localparam int REG_AW    = 3;  // eight architectural registers per file

    // destination kind of a result slot
    typedef enum logic [1:0] {
        KIND_NONE = 2'd0,
        KIND_REG  = 2'd1,
        KIND_SEG  = 2'd2,
        KIND_MEM  = 2'd3
    } slot_kind_e;

    typedef struct packed {
        logic [63:0] value;
        logic [31:0] dest;         // reg number in [2:0], else memory address
        slot_kind_e  kind;
        logic        wb;
    } wb_slot_t;

    typedef struct packed {
        wb_slot_t [NUM_SLOTS-1:0] slots;
        logic [1:0]  size;         // operand size
        logic [31:0] eip;
        logic [31:0] eip_next;     // fall-through
        logic        br_valid;
        logic        br_taken;
        logic        br_correct;
        logic [31:0] br_target;
        logic        ld_eip_cs;    // far transfer, EIP comes from slot 1
        logic [15:0] cs;
        logic        exc;
        logic [2:0]  exc_type;
        logic        halt_op;
    } ex_wb_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [63:0] data;
        logic [1:0]  size;
    } mem_wr_t;

    typedef struct packed {
        logic        resteer;
        logic [31:0] new_eip;
        logic [31:0] fip_e;        // even 16-byte fetch line
        logic [31:0] fip_o;        // odd 16-byte fetch line
    } redirect_t;

endpackage
